//--- files.f
+incdir+include
logic/pinballPkg.sv
logic/frameTicker.sv
logic/ballCollision.sv
logic/ballController.sv
logic/pinballRegs.sv
logic/pinballTop.sv
testbench/pinball_assertions.sv
testbench/pinballTb.sv

//--- run.sh
#!/bin/sh
# build and run the pinball testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module pinballTb \
	-Mdir obj_dir -o pinballSim &&
./obj_dir/pinballSim | tee /dev/stderr | grep -q '^>>> PASS$' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- testbench/pinballTb.sv
`include "pinball_defs.svh"

module pinballTb import pinballPkg::*; ();

	localparam int maxCycles = 20000;   // six tests at 16 cycles a frame, plus margin.

	logic clk = 1'b0;
	logic resetN;
	apbReq apbIn;
	apbRsp apbOut;
	logic flipperUp;
	ballPos ball;
	logic frameStart;

	int errors = 0;
	int cycles = 0;
	logic closed = 1'b0;

	// reference model, fixed point.
	int mXFix;
	int mYFix;
	int mXSpeed;
	int mYSpeed;
	int mKick = 0;
	int flips = 0;
	logic mPause = 1'b0;
	logic resetPending = 1'b0;

	pinballTop UUT (.*);

	always #20 clk = ~clk;

	function automatic int toPixel(int fix);
		logic signed [10:0] p;
		p = 11'(fix >>> `FIX_SHIFT);
		return int'(p);
	endfunction

	task automatic checkValue(string name, int got, int exp);
		assert (got == exp) else begin
			errors++;
			$display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkTrue(logic cond, string what);
		assert (cond) else begin
			errors++;
			$display("ERROR t=%0t %s", $time, what);
		end
	endtask

	task automatic modelInit();
		mXFix = `BALL_INIT_X << `FIX_SHIFT;
		mYFix = `BALL_INIT_Y << `FIX_SHIFT;
		mXSpeed = 0;
		mYSpeed = 0;
	endtask

	task automatic modelFrame();
		int x;
		int y;
		logic flip;
		mYFix = mYFix + mYSpeed;
		mYSpeed = mYSpeed + `GRAVITY;
		mXFix = mXFix + mXSpeed;
		x = toPixel(mXFix);
		y = toPixel(mYFix);
		flip = flipperUp && (y + `BALL_SIZE >= `FLIP_Y) && (y < `SCREEN_H)
			&& (x + `BALL_SIZE > `FLIP_X0) && (x < `FLIP_X1) && (mYSpeed > 0);
		if ((y <= 0 && mYSpeed < 0) || flip)
			mYSpeed = -mYSpeed;
		if ((x <= 0 && mXSpeed < 0) || (x + `BALL_SIZE >= `SCREEN_W && mXSpeed > 0))
			mXSpeed = -mXSpeed;
		else if (flip)
			mXSpeed = mXSpeed + mKick;
		if (flip)
			flips++;
	endtask

	always @(negedge clk) begin
		if (resetPending) begin
			modelInit();   // level reset beats a frame tick.
			resetPending = 1'b0;
		end
		else if (frameStart && !mPause)
			modelFrame();
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= maxCycles) begin
			$display("timeout after %0d cycles, errors: %0d", cycles, errors);
			closed = 1'b1;
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic apbAccess(logic write, logic [7:0] addr, logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk);
		apbIn.psel <= 1'b1;
		apbIn.penable <= 1'b0;
		apbIn.pwrite <= write;
		apbIn.paddr <= addr;
		apbIn.pwdata <= wdata;
		@(posedge clk);
		apbIn.penable <= 1'b1;
		@(negedge clk);
		checkTrue(apbOut.pready, "pready low in an APB access cycle");
		rdata = apbOut.prdata;
		err = apbOut.pslverr;
		@(posedge clk);   // write lands on this edge.
		apbIn.psel <= 1'b0;
		apbIn.penable <= 1'b0;
	endtask

	task automatic apbWrite(logic [7:0] addr, logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		apbAccess(1'b1, addr, data, rdata, err);
		checkValue("pslverr", int'(err), 0);
		if (addr == `REG_CTRL) begin
			mPause = data[0];
			resetPending = data[1];
		end
		else if (addr == `REG_KICK)
			mKick = data;
	endtask

	task automatic apbRead(logic [7:0] addr, output logic [31:0] data, output logic err);
		apbAccess(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic waitFrame();
		do begin
			@(negedge clk);
		end while (!frameStart);
		@(negedge clk);
		checkValue("ball.x", int'(ball.x), toPixel(mXFix));
		checkValue("ball.y", int'(ball.y), toPixel(mYFix));
	endtask

	task automatic testReset();
		logic [31:0] data;
		logic err;
		checkValue("ball.x", int'(ball.x), `BALL_INIT_X);
		checkValue("ball.y", int'(ball.y), `BALL_INIT_Y);
		apbRead(`REG_POS, data, err);
		checkValue("pos", int'(data), (`BALL_INIT_Y << 16) | `BALL_INIT_X);
		checkValue("pslverr", int'(err), 0);
		apbRead(8'h10, data, err);
		checkValue("pslverr", int'(err), 1);
	endtask

	task automatic testPause();
		ballPos held;
		apbWrite(`REG_CTRL, 32'd1);
		@(negedge clk);
		held = ball;
		repeat (5) begin
			waitFrame();
			checkValue("ball.y", int'(ball.y), int'(held.y));
		end
		apbWrite(`REG_CTRL, 32'd0);
		repeat (5) waitFrame();
	endtask

	task automatic testLevelReset();
		repeat (3) waitFrame();
		apbWrite(`REG_CTRL, 32'd2);
		@(posedge clk);
		@(negedge clk);
		checkValue("ball.x", int'(ball.x), `BALL_INIT_X);
		checkValue("ball.y", int'(ball.y), `BALL_INIT_Y);
		repeat (8) waitFrame();
	endtask

	task automatic testFlipper();
		int prevX;
		int prevY;
		int n;
		apbWrite(`REG_KICK, 32'd40);
		@(posedge clk);
		flipperUp <= 1'b1;
		apbWrite(`REG_CTRL, 32'd2);   // drop from the top again.
		flips = 0;
		n = 0;
		while (flips == 0 && n < 120) begin
			waitFrame();
			n++;
		end
		checkTrue(flips > 0, "ball never reached the flipper");
		checkTrue(int'(ball.y) >= `FLIP_Y - `BALL_SIZE, "flipper kicked above its zone");
		prevX = ball.x;
		prevY = ball.y;
		repeat (15) begin
			waitFrame();
			checkTrue(int'(ball.y) < prevY, "ball did not rise after the flipper kick");
			checkTrue(int'(ball.x) > prevX, "ball did not move right after the kick");
			prevX = ball.x;
			prevY = ball.y;
		end
		@(posedge clk);
		flipperUp <= 1'b0;
	endtask

	task automatic testPeriodClamp();
		logic [31:0] data;
		logic err;
		int gap;
		apbWrite(`REG_PERIOD, 32'd3);
		apbRead(`REG_PERIOD, data, err);
		checkValue("period", int'(data), `MIN_FRAME_PERIOD);
		waitFrame();
		gap = 1;
		while (!frameStart) begin
			@(negedge clk);
			gap++;
		end
		checkValue("frame gap", gap, `MIN_FRAME_PERIOD);
	endtask

	initial begin
		resetN = 1'b0;
		apbIn = '0;
		flipperUp = 1'b0;
		modelInit();
		repeat (5) @(posedge clk);
		resetN <= 1'b1;
		@(negedge clk);
		testReset();
		apbWrite(`REG_PERIOD, 32'd16);   // free fall.
		repeat (20) waitFrame();
		checkValue("ball.x", int'(ball.x), `BALL_INIT_X);
		testPause();
		testLevelReset();
		testFlipper();
		testPeriodClamp();
		closed = 1'b1;
		$display("errors: %0d", errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	final begin
		if (!closed)
			$display(">>> FAIL");
	end

endmodule

//--- testbench/pinball_assertions.sv
module pinballAssertions import pinballPkg::*; (
	input	logic		clk,
	input	logic		resetN,
	input	apbReq		apbIn,
	input	apbRsp		apbOut,
	input	logic		frameStart,
	input	logic		levelReset,
	input	ballPos		ball
);

	// pready belongs to the access phase only, right after a setup cycle.
	assert property (@(posedge clk) disable iff (!resetN)
		apbOut.pready |-> (apbIn.psel && apbIn.penable
			&& $past(apbIn.psel && !apbIn.penable)))
		else $error("pready high outside an APB access cycle");

	assert property (@(posedge clk) disable iff (!resetN)
		frameStart |=> !frameStart)
		else $error("frameStart high on two cycles in a row");

	// y moves only after a frame tick or a level reset.
	assert property (@(posedge clk) disable iff (!resetN)
		(!frameStart && !levelReset) |=> $stable(ball.y))
		else $error("ball.y changed without a frame tick");

endmodule

bind pinballTop pinballAssertions checks (
	.clk		(clk),
	.resetN		(resetN),
	.apbIn		(apbIn),
	.apbOut		(apbOut),
	.frameStart	(frameStart),
	.levelReset	(cfg.levelReset),
	.ball		(ball)
);

//--- logic/pinballTop.sv
module pinballTop import pinballPkg::*; (
	input	logic		clk,
	input	logic		resetN,
	input	apbReq		apbIn,
	output	apbRsp		apbOut,
	input	logic		flipperUp,
	output	ballPos		ball,
	output	logic		frameStart
);

	ballCfg cfg;
	hitFlags hits;
	logic periodWritten;

	pinballRegs regs (
		.clk			(clk),
		.resetN			(resetN),
		.req			(apbIn),
		.rsp			(apbOut),
		.ball			(ball),
		.cfg			(cfg),
		.periodWritten	(periodWritten)
	);

	frameTicker ticker (
		.clk			(clk),
		.resetN			(resetN),
		.framePeriod	(cfg.framePeriod),
		.restart		(periodWritten),
		.frameStart		(frameStart)
	);

	ballCollision collision (
		.ball			(ball),
		.flipperUp		(flipperUp),
		.hits			(hits)
	);

	ballController controller (
		.clk			(clk),
		.resetN			(resetN),
		.frameStart		(frameStart),
		.hits			(hits),
		.cfg			(cfg),
		.ball			(ball)
	);

endmodule

//--- logic/pinballRegs.sv
`include "pinball_defs.svh"

module pinballRegs import pinballPkg::*; (
	input	logic		clk,
	input	logic		resetN,
	input	apbReq		req,
	output	apbRsp		rsp,
	input	ballPos		ball,
	output	ballCfg		cfg,
	output	logic		periodWritten
);

	logic access;
	logic addrValid;
	logic doWrite;
	logic [15:0] periodIn;

	assign access = req.psel && req.penable;
	assign doWrite = access && req.pwrite && addrValid;

	assign rsp.pready = access;   // no wait states.
	assign rsp.pslverr = access && !addrValid;

	always_comb begin
		addrValid = 1'b1;
		rsp.prdata = 32'd0;
		case (req.paddr)
			addrCtrl: rsp.prdata = {31'd0, cfg.pause};
			addrKick: rsp.prdata = cfg.flipperKickX;
			addrPeriod: rsp.prdata = {16'd0, cfg.framePeriod};
			addrPos: rsp.prdata = {5'd0, ball.y, 5'd0, ball.x};
			default: addrValid = 1'b0;
		endcase
	end

	// short periods are raised to the minimum.
	assign periodIn = (req.pwdata[15:0] < 16'(`MIN_FRAME_PERIOD)) ?
		16'(`MIN_FRAME_PERIOD) : req.pwdata[15:0];

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cfg.pause <= 1'b0;
			cfg.levelReset <= 1'b0;
			cfg.flipperKickX <= 32'sd0;
			cfg.framePeriod <= 16'(`DEFAULT_PERIOD);
			periodWritten <= 1'b0;
		end
		else begin
			cfg.levelReset <= doWrite && (req.paddr == addrCtrl) && req.pwdata[1];
			periodWritten <= doWrite && (req.paddr == addrPeriod);
			if (doWrite) begin
				case (req.paddr)
					addrCtrl: cfg.pause <= req.pwdata[0];
					addrKick: cfg.flipperKickX <= req.pwdata;
					addrPeriod: cfg.framePeriod <= periodIn;
					default: ;   // pos is read only.
				endcase
			end
		end
	end

endmodule

//--- logic/ballController.sv
`include "pinball_defs.svh"

module ballController import pinballPkg::*; (
	input	logic		clk,
	input	logic		resetN,
	input	logic		frameStart,
	input	hitFlags	hits,
	input	ballCfg		cfg,
	output	ballPos		ball
);

	int xSpeed;
	int ySpeed;
	int xFix;
	int yFix;

	logic bounceY;
	logic bounceX;
	logic flipperHit;

	// speed sign guards keep a long contact from flipping twice.
	assign flipperHit = hits.flipper && (ySpeed > 0);
	assign bounceY = (hits.borderTop && (ySpeed < 0))
		|| (hits.obstacle && hits.edgeCode[2] && (ySpeed < 0))
		|| (hits.obstacle && hits.edgeCode[0] && (ySpeed > 0));
	assign bounceX = (hits.borderLeft && (xSpeed < 0))
		|| (hits.borderRight && (xSpeed > 0))
		|| (hits.obstacle && hits.edgeCode[3] && (xSpeed < 0))
		|| (hits.obstacle && hits.edgeCode[1] && (xSpeed > 0));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			ySpeed <= 0;
			yFix <= `BALL_INIT_Y << `FIX_SHIFT;
		end
		else if (cfg.levelReset) begin
			ySpeed <= 0;
			yFix <= `BALL_INIT_Y << `FIX_SHIFT;
		end
		else if (!cfg.pause) begin
			if (frameStart) begin
				yFix <= yFix + ySpeed;
				ySpeed <= ySpeed + `GRAVITY;
			end
			else if (bounceY || flipperHit) begin
				ySpeed <= -ySpeed;
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xSpeed <= 0;
			xFix <= `BALL_INIT_X << `FIX_SHIFT;
		end
		else if (cfg.levelReset) begin
			xSpeed <= 0;
			xFix <= `BALL_INIT_X << `FIX_SHIFT;
		end
		else if (!cfg.pause) begin
			if (frameStart) begin
				xFix <= xFix + xSpeed;
			end
			else if (bounceX) begin
				xSpeed <= -xSpeed;
			end
			else if (flipperHit) begin
				xSpeed <= xSpeed + cfg.flipperKickX;   // kick sideways.
			end
		end
	end

	assign ball.x = 11'(xFix >>> `FIX_SHIFT);
	assign ball.y = 11'(yFix >>> `FIX_SHIFT);

endmodule

//--- logic/ballCollision.sv
`include "pinball_defs.svh"

module ballCollision import pinballPkg::*; (
	input	ballPos		ball,
	input	logic		flipperUp,
	output	hitFlags	hits
);

	int left;
	int top;
	int right;
	int bottom;
	int penTop;
	int penBottom;
	int penLeft;
	int penRight;
	logic overlap;

	always_comb begin
		left = ball.x;
		top = ball.y;
		right = left + `BALL_SIZE;   // one past the last pixel.
		bottom = top + `BALL_SIZE;

		hits.borderTop = (top <= 0);
		hits.borderLeft = (left <= 0);
		hits.borderRight = (right >= `SCREEN_W);

		// flipper zone only counts while the pin is held.
		hits.flipper = flipperUp && (bottom >= `FLIP_Y) && (top < `SCREEN_H)
			&& (right > `FLIP_X0) && (left < `FLIP_X1);

		overlap = (right > `OBST_X0) && (left < `OBST_X1)
			&& (bottom > `OBST_Y0) && (top < `OBST_Y1);
		hits.obstacle = overlap;

		penTop = bottom - `OBST_Y0;
		penBottom = `OBST_Y1 - top;
		penLeft = right - `OBST_X0;
		penRight = `OBST_X1 - left;

		// face of least penetration wins.
		hits.edgeCode = 4'b0000;
		if (overlap) begin
			if ((penTop <= penBottom) && (penTop <= penLeft) && (penTop <= penRight))
				hits.edgeCode = 4'b0001;
			else if ((penBottom <= penLeft) && (penBottom <= penRight))
				hits.edgeCode = 4'b0100;
			else if (penLeft <= penRight)
				hits.edgeCode = 4'b0010;
			else
				hits.edgeCode = 4'b1000;
		end
	end

endmodule

//--- logic/frameTicker.sv
`include "pinball_defs.svh"

module frameTicker (
	input	logic			clk,
	input	logic			resetN,
	input	logic	[15:0]	framePeriod,
	input	logic			restart,
	output	logic			frameStart
);

	logic [15:0] count;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			count <= 16'(`DEFAULT_PERIOD - 1);
			frameStart <= 1'b0;
		end
		else if (restart) begin
			count <= framePeriod - 16'd1;   // new period takes effect now.
			frameStart <= 1'b0;
		end
		else if (count == 16'd0) begin
			count <= framePeriod - 16'd1;
			frameStart <= 1'b1;
		end
		else begin
			count <= count - 16'd1;
			frameStart <= 1'b0;
		end
	end

endmodule

//--- logic/pinballPkg.sv
`include "pinball_defs.svh"

package pinballPkg;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic pready;
		logic pslverr;
		logic [31:0] prdata;
	} apbRsp;

	// edgeCode is one-hot: top, left, bottom, right face of the obstacle.
	typedef struct packed {
		logic borderTop;
		logic borderLeft;
		logic borderRight;
		logic flipper;
		logic obstacle;
		logic [3:0] edgeCode;
	} hitFlags;

	typedef struct packed {
		logic pause;
		logic levelReset;   // one cycle pulse.
		logic signed [31:0] flipperKickX;
		logic [15:0] framePeriod;
	} ballCfg;

	typedef struct packed {
		logic signed [10:0] x;
		logic signed [10:0] y;
	} ballPos;

	typedef enum logic [7:0] {
		addrCtrl = `REG_CTRL,
		addrKick = `REG_KICK,
		addrPeriod = `REG_PERIOD,
		addrPos = `REG_POS
	} regAddr;

endpackage

//--- include/pinball_defs.svh
`ifndef PINBALL_DEFS_SVH
`define PINBALL_DEFS_SVH

`define SCREEN_W 640
`define SCREEN_H 480
`define BALL_INIT_X 320
`define BALL_INIT_Y 40
`define BALL_SIZE 16
`define FIX_SHIFT 4
`define GRAVITY 3
`define OBST_X0 100
`define OBST_Y0 250
`define OBST_X1 180
`define OBST_Y1 290
`define FLIP_Y 440
`define FLIP_X0 240
`define FLIP_X1 400
`define MIN_FRAME_PERIOD 8
`define DEFAULT_PERIOD 1000   // frame period out of reset.

`define REG_CTRL 8'h00
`define REG_KICK 8'h04
`define REG_PERIOD 8'h08
`define REG_POS 8'h0C

`endif
